//--- Makefile
# Verilator build and run of the memory-event monitor testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_mem_event_monitor -f list.f -o Vtb_mem_event_monitor
	./obj_dir/Vtb_mem_event_monitor 2>&1 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
rtl/mon_pkg.sv
rtl/mon_event_if.sv
rtl/mem_region_classifier.sv
rtl/dma_event_sync.sv
rtl/event_counter_bank.sv
rtl/mem_event_monitor.sv
testbench/mem_event_monitor_props.sv
testbench/tb_mem_event_monitor.sv

//--- rtl/dma_event_sync.sv
// DMA event receiver turning the cluster's four-phase request into one pulse
`timescale 1ns/1ps

module dma_event_sync (
  input  logic clk_i,
  input  logic rst_i,
  input  logic evt_valid_i,
  output logic evt_ack_o,
  output logic evt_pulse_o
);

  logic sync_q1;
  logic sync_q2;
  logic level_q;

  // Two-flop synchronizer, then one more stage for edge detect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      level_q <= 1'b0;
    end else begin
      sync_q1 <= evt_valid_i;
      sync_q2 <= sync_q1;
      level_q <= sync_q2;
    end
  end

  // Ack follows the synchronized level so the sender can drop valid
  assign evt_ack_o = sync_q2;

  // One pulse per request on the rising level
  assign evt_pulse_o = sync_q2 & ~level_q;

endmodule

//--- rtl/event_counter_bank.sv
// Event counter bank counting memory and DMA events, served on a small config port
`timescale 1ns/1ps

module event_counter_bank (
  input  logic                 clk_i,
  input  logic                 rst_i,
  mon_event_if.sink            evt_i,
  input  logic                 dma_pulse_i,
  // Read channel
  input  logic                 cfg_ar_valid_i,
  input  mon_pkg::lite_addr_t  cfg_ar_addr_i,
  output logic                 cfg_ar_ready_o,
  output logic                 cfg_r_valid_o,
  output mon_pkg::lite_data_t  cfg_r_data_o,
  input  logic                 cfg_r_ready_i,
  // Write channel, only used as a clear strobe
  input  logic                 cfg_aw_valid_i,
  input  logic                 cfg_w_valid_i,
  output logic                 cfg_aw_ready_o,
  output logic                 cfg_w_ready_o,
  output logic                 cfg_b_valid_o,
  input  logic                 cfg_b_ready_i
);

  mon_pkg::cnt_t                cnt_q [mon_pkg::NumCounters];
  logic [mon_pkg::NumCounters-1:0] inc;
  mon_pkg::cnt_idx_t            evt_idx;

  logic                         rd_accept;
  logic                         wr_accept;
  mon_pkg::lite_addr_t          rd_word;
  mon_pkg::lite_data_t          rd_data;

  logic                         r_valid_q;
  mon_pkg::lite_data_t          r_data_q;
  logic                         b_valid_q;

  // Region selects the group of four, kind the counter in it
  assign evt_idx = mon_pkg::cnt_idx_t'({evt_i.region, evt_i.kind});

  always_comb begin
    inc = '0;
    if (evt_i.valid && evt_i.addr_hit) begin
      inc[evt_idx] = 1'b1;
    end
    if (dma_pulse_i) begin
      inc[mon_pkg::DmaCntIdx] = 1'b1;
    end
  end

  // Clear wins over a same-cycle increment
  for (genvar n = 0; n < mon_pkg::NumCounters; n++) begin : gen_cnt
    always_ff @(posedge clk_i) begin
      if (rst_i || wr_accept) begin
        cnt_q[n] <= '0;
      end else if (inc[n]) begin
        cnt_q[n] <= cnt_q[n] + 1'b1;
      end
    end
  end

  // Read channel
  assign rd_accept = cfg_ar_valid_i & ~r_valid_q;
  assign rd_word   = cfg_ar_addr_i >> 2;

  always_comb begin
    if (rd_word < mon_pkg::NumCounters) begin
      rd_data = mon_pkg::lite_data_t'(cnt_q[rd_word[mon_pkg::CntIdxWidth-1:0]]);
    end else begin
      rd_data = mon_pkg::UnmappedData;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_accept) begin
      r_valid_q <= 1'b1;
    end else if (cfg_r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Data captured at acceptance and held with the response
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= rd_data;
    end
  end

  assign cfg_ar_ready_o = ~r_valid_q;
  assign cfg_r_valid_o  = r_valid_q;
  assign cfg_r_data_o   = r_data_q;

  // Write channel
  assign wr_accept = cfg_aw_valid_i & cfg_w_valid_i & ~b_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (cfg_b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  assign cfg_aw_ready_o = ~b_valid_q;
  assign cfg_w_ready_o  = ~b_valid_q;
  assign cfg_b_valid_o  = b_valid_q;

endmodule

//--- rtl/mem_event_monitor.sv
// Memory-event monitor top joining the region classifier, DMA receiver and counters
`timescale 1ns/1ps

module mem_event_monitor (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Memory access
  input  logic                 acc_valid_i,
  input  mon_pkg::addr_t       acc_addr_i,
  input  logic                 acc_write_i,
  input  logic                 acc_hit_i,
  // DMA event from the cluster
  input  logic                 dma_evt_valid_i,
  output logic                 dma_evt_ack_o,
  // Configuration read
  input  logic                 cfg_ar_valid_i,
  input  mon_pkg::lite_addr_t  cfg_ar_addr_i,
  output logic                 cfg_ar_ready_o,
  output logic                 cfg_r_valid_o,
  output mon_pkg::lite_data_t  cfg_r_data_o,
  input  logic                 cfg_r_ready_i,
  // Configuration write
  input  logic                 cfg_aw_valid_i,
  input  logic                 cfg_w_valid_i,
  output logic                 cfg_aw_ready_o,
  output logic                 cfg_w_ready_o,
  output logic                 cfg_b_valid_o,
  input  logic                 cfg_b_ready_i
);

  logic dma_evt;

  mon_event_if mem_evt ();

  mem_region_classifier i_mem_region_classifier (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .acc_valid_i ( acc_valid_i ),
    .acc_addr_i  ( acc_addr_i  ),
    .acc_write_i ( acc_write_i ),
    .acc_hit_i   ( acc_hit_i   ),
    .evt_o       ( mem_evt     )
  );

  dma_event_sync i_dma_event_sync (
    .clk_i       ( clk_i           ),
    .rst_i       ( rst_i           ),
    .evt_valid_i ( dma_evt_valid_i ),
    .evt_ack_o   ( dma_evt_ack_o   ),
    .evt_pulse_o ( dma_evt         )
  );

  event_counter_bank i_event_counter_bank (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .evt_i          ( mem_evt        ),
    .dma_pulse_i    ( dma_evt        ),
    .cfg_ar_valid_i ( cfg_ar_valid_i ),
    .cfg_ar_addr_i  ( cfg_ar_addr_i  ),
    .cfg_ar_ready_o ( cfg_ar_ready_o ),
    .cfg_r_valid_o  ( cfg_r_valid_o  ),
    .cfg_r_data_o   ( cfg_r_data_o   ),
    .cfg_r_ready_i  ( cfg_r_ready_i  ),
    .cfg_aw_valid_i ( cfg_aw_valid_i ),
    .cfg_w_valid_i  ( cfg_w_valid_i  ),
    .cfg_aw_ready_o ( cfg_aw_ready_o ),
    .cfg_w_ready_o  ( cfg_w_ready_o  ),
    .cfg_b_valid_o  ( cfg_b_valid_o  ),
    .cfg_b_ready_i  ( cfg_b_ready_i  )
  );

endmodule

//--- rtl/mem_region_classifier.sv
// Region classifier that registers each memory access as a region and hit/miss event
`timescale 1ns/1ps

module mem_region_classifier (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            acc_valid_i,
  input  mon_pkg::addr_t  acc_addr_i,
  input  logic            acc_write_i,
  input  logic            acc_hit_i,
  mon_event_if.source     evt_o
);

  logic                 match_hit;
  mon_pkg::region_idx_t match_idx;
  mon_pkg::event_kind_e acc_kind;

  logic                 valid_q;
  logic                 hit_q;
  mon_pkg::region_idx_t region_q;
  mon_pkg::event_kind_e kind_q;

  // Address decode against the region map
  always_comb begin
    match_hit = 1'b0;
    match_idx = '0;
    for (int unsigned r = 0; r < mon_pkg::NumRegions; r++) begin
      if (acc_addr_i >= mon_pkg::region_map[r].start_addr &&
          acc_addr_i <  mon_pkg::region_map[r].end_addr) begin
        match_hit = 1'b1;
        match_idx = mon_pkg::region_map[r].idx;
      end
    end
  end

  // Kind is {write, miss}
  assign acc_kind = mon_pkg::event_kind_e'({acc_write_i, ~acc_hit_i});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= acc_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      hit_q    <= match_hit;
      region_q <= match_idx;
      kind_q   <= acc_kind;
    end
  end

  assign evt_o.valid    = valid_q;
  assign evt_o.addr_hit = hit_q;
  assign evt_o.region   = region_q;
  assign evt_o.kind     = kind_q;

endmodule

//--- rtl/mon_event_if.sv
// Classified memory event link from the region classifier to the counter bank
`timescale 1ns/1ps

interface mon_event_if;

  logic                 valid;
  mon_pkg::region_idx_t region;
  mon_pkg::event_kind_e kind;
  // Low when the address fell outside every region
  logic                 addr_hit;

  modport source (
    output valid,
    output region,
    output kind,
    output addr_hit
  );

  // No back-pressure, the sink takes every valid event
  modport sink (
    input valid,
    input region,
    input kind,
    input addr_hit
  );

endinterface

//--- rtl/mon_pkg.sv
// Memory-event monitor package with widths, region map, event kinds and counter layout
package mon_pkg;

  // Memory access side
  localparam int unsigned AddrWidth = 64;

  // Configuration port
  localparam int unsigned LiteAddrWidth = 32;
  localparam int unsigned LiteDataWidth = 32;

  // Counter bank geometry
  localparam int unsigned CntWidth    = 32;
  localparam int unsigned NumRegions  = 2;
  localparam int unsigned NumKinds    = 4;
  localparam int unsigned NumCounters = NumRegions * NumKinds + 1;
  localparam int unsigned DmaCntIdx   = NumCounters - 1;
  localparam int unsigned CntIdxWidth = $clog2(NumCounters);

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic                     region_idx_t;
  typedef logic [CntWidth-1:0]      cnt_t;
  typedef logic [CntIdxWidth-1:0]   cnt_idx_t;
  typedef logic [LiteAddrWidth-1:0] lite_addr_t;
  typedef logic [LiteDataWidth-1:0] lite_data_t;

  // Region boundaries
  localparam addr_t DebugBase   = 64'h0000_0000_0000_0000;
  localparam addr_t HyperBase   = 64'h0000_0000_8000_0000;
  localparam addr_t HyperLength = 64'h0000_0000_4000_0000;

  // Returned on a read outside the counter range
  localparam lite_data_t UnmappedData = 32'hDEAD_F000;

  // Encoding is {write, miss}, so the counter index is region * 4 + kind
  typedef enum logic [1:0] {
    read_hit   = 2'd0,
    read_miss  = 2'd1,
    write_hit  = 2'd2,
    write_miss = 2'd3
  } event_kind_e;

  typedef struct packed {
    region_idx_t idx;
    addr_t       start_addr;
    addr_t       end_addr;
  } addr_rule_t;

  // End addresses are exclusive
  localparam addr_rule_t region_map [NumRegions] = '{
    '{idx: 1'b0, start_addr: DebugBase, end_addr: HyperBase},
    '{idx: 1'b1, start_addr: HyperBase, end_addr: HyperBase + HyperLength}
  };

endpackage

//--- testbench/mem_event_monitor_props.sv
// Handshake and reset assertions for the memory-event monitor, bound to the top level
`timescale 1ns/1ps

module mem_event_monitor_props (
  input logic                clk_i,
  input logic                rst_i,
  input logic                dma_evt_valid_i,
  input logic                dma_evt_ack_o,
  input logic                cfg_ar_ready_o,
  input logic                cfg_r_valid_o,
  input mon_pkg::lite_data_t cfg_r_data_o,
  input logic                cfg_r_ready_i,
  input logic                cfg_aw_ready_o,
  input logic                cfg_w_ready_o,
  input logic                cfg_b_valid_o,
  input logic                cfg_b_ready_i
);

  // Read response held with stable data until taken
  r_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_r_valid_o && !cfg_r_ready_i |=> cfg_r_valid_o && $stable(cfg_r_data_o))
    else $error("read response dropped or changed before r_ready");

  b_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o)
    else $error("write response dropped before b_ready");

  ar_ready_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_ar_ready_o == !cfg_r_valid_o)
    else $error("ar_ready is not the inverse of r_valid");

  w_ready_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_aw_ready_o == !cfg_b_valid_o && cfg_w_ready_o == !cfg_b_valid_o)
    else $error("aw_ready or w_ready is not the inverse of b_valid");

  // All response and ack outputs are low one edge into reset
  reset_a: assert property (@(posedge clk_i)
    rst_i |=> !cfg_r_valid_o && !cfg_b_valid_o && !dma_evt_ack_o)
    else $error("response or ack still high after reset");

  ack_rise_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(dma_evt_ack_o) |-> dma_evt_valid_i)
    else $error("dma ack rose without a pending request");

endmodule

bind mem_event_monitor mem_event_monitor_props i_mem_event_monitor_props (
  .clk_i           ( clk_i           ),
  .rst_i           ( rst_i           ),
  .dma_evt_valid_i ( dma_evt_valid_i ),
  .dma_evt_ack_o   ( dma_evt_ack_o   ),
  .cfg_ar_ready_o  ( cfg_ar_ready_o  ),
  .cfg_r_valid_o   ( cfg_r_valid_o   ),
  .cfg_r_data_o    ( cfg_r_data_o    ),
  .cfg_r_ready_i   ( cfg_r_ready_i   ),
  .cfg_aw_ready_o  ( cfg_aw_ready_o  ),
  .cfg_w_ready_o   ( cfg_w_ready_o   ),
  .cfg_b_valid_o   ( cfg_b_valid_o   ),
  .cfg_b_ready_i   ( cfg_b_ready_i   )
);

//--- testbench/tb_mem_event_monitor.sv
// Testbench for the memory-event monitor, checking read-back counts against reference counts
`timescale 1ns/1ps

module tb_mem_event_monitor;

  logic                clk_i;
  logic                rst_i;
  logic                acc_valid_i;
  mon_pkg::addr_t      acc_addr_i;
  logic                acc_write_i;
  logic                acc_hit_i;
  logic                dma_evt_valid_i;
  logic                dma_evt_ack_o;
  logic                cfg_ar_valid_i;
  mon_pkg::lite_addr_t cfg_ar_addr_i;
  logic                cfg_ar_ready_o;
  logic                cfg_r_valid_o;
  mon_pkg::lite_data_t cfg_r_data_o;
  logic                cfg_r_ready_i;
  logic                cfg_aw_valid_i;
  logic                cfg_w_valid_i;
  logic                cfg_aw_ready_o;
  logic                cfg_w_ready_o;
  logic                cfg_b_valid_o;
  logic                cfg_b_ready_i;

  int unsigned ref_cnt [mon_pkg::NumCounters];
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  int          wait_limit = 64;

  mem_event_monitor i_mem_event_monitor (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Reference index from the region bounds and {write, miss}, -1 when unmapped
  function automatic int ref_index(mon_pkg::addr_t addr, logic wr, logic hit);
    int region;
    if (addr >= mon_pkg::DebugBase && addr < mon_pkg::HyperBase) begin
      region = 0;
    end else if (addr >= mon_pkg::HyperBase &&
                 addr < mon_pkg::HyperBase + mon_pkg::HyperLength) begin
      region = 1;
    end else begin
      return -1;
    end
    return region * 4 + (wr ? 2 : 0) + (hit ? 0 : 1);
  endfunction

  function automatic logic port_value(string name);
    case (name)
      "ar_ready": return cfg_ar_ready_o;
      "r_valid":  return cfg_r_valid_o;
      "aw_ready": return cfg_aw_ready_o & cfg_w_ready_o;
      "b_valid":  return cfg_b_valid_o;
      default:    return dma_evt_ack_o;
    endcase
  endfunction

  // Polled on the falling edge, where outputs have settled
  task automatic wait_for(string name, logic level);
    int t;
    t = 0;
    @(negedge clk_i);
    while (port_value(name) !== level && t < wait_limit) begin
      @(negedge clk_i);
      t++;
    end
    if (port_value(name) !== level) begin
      $display("Timed out at %0t waiting for %s to become %0b", $time, name, level);
      errors++;
    end
  endtask

  task automatic random_accesses(int n);
    mon_pkg::addr_t addr;
    logic           wr;
    logic           hit;
    int             idx;
    for (int i = 0; i < n; i++) begin
      case ($urandom % 4)
        0:       addr = {32'h0, 1'b0, 31'($urandom)};
        1:       addr = mon_pkg::HyperBase + {34'h0, 30'($urandom)};
        2:       addr = {32'h0, 2'b11, 30'($urandom)};
        default: addr = {$urandom, $urandom};
      endcase
      wr  = 1'($urandom);
      hit = 1'($urandom);
      idx = ref_index(addr, wr, hit);
      if (idx >= 0) begin
        ref_cnt[idx]++;
      end
      @(posedge clk_i);
      acc_valid_i <= 1'b1;
      acc_addr_i  <= addr;
      acc_write_i <= wr;
      acc_hit_i   <= hit;
    end
    @(posedge clk_i);
    acc_valid_i <= 1'b0;
  endtask

  task automatic read_counter(int idx, output mon_pkg::lite_data_t data);
    @(posedge clk_i);
    cfg_ar_valid_i <= 1'b1;
    // Bits 1:0 are don't care
    cfg_ar_addr_i  <= mon_pkg::lite_addr_t'(idx * 4) | mon_pkg::lite_addr_t'($urandom % 4);
    wait_for("ar_ready", 1'b1);
    @(posedge clk_i);
    cfg_ar_valid_i <= 1'b0;
    wait_for("r_valid", 1'b1);
    data = cfg_r_data_o;
    @(posedge clk_i);
  endtask

  task automatic check_counter(int idx, mon_pkg::lite_data_t exp);
    mon_pkg::lite_data_t got;
    read_counter(idx, got);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t: counter %0d read 0x%08h, expected 0x%08h", $time, idx, got, exp);
      errors++;
    end
  endtask

  task automatic check_all_counters();
    for (int n = 0; n < mon_pkg::NumCounters; n++) begin
      check_counter(n, ref_cnt[n]);
    end
  endtask

  // Four-phase request, ack must rise and then fall
  task automatic dma_request();
    @(posedge clk_i);
    dma_evt_valid_i <= 1'b1;
    wait_for("ack", 1'b1);
    @(posedge clk_i);
    dma_evt_valid_i <= 1'b0;
    wait_for("ack", 1'b0);
    ref_cnt[mon_pkg::DmaCntIdx]++;
  endtask

  task automatic held_read();
    mon_pkg::lite_data_t first;
    @(posedge clk_i);
    cfg_r_ready_i <= 1'b0;
    read_counter(mon_pkg::DmaCntIdx, first);
    for (int c = 0; c < 6; c++) begin
      @(negedge clk_i);
      checks++;
      assert (cfg_r_valid_o && !cfg_ar_ready_o && cfg_r_data_o === first &&
              first === ref_cnt[mon_pkg::DmaCntIdx]) else begin
        $display("Fail %0t: held response r_valid %0b ar_ready %0b data 0x%08h", $time,
                 cfg_r_valid_o, cfg_ar_ready_o, cfg_r_data_o);
        errors++;
      end
    end
    @(posedge clk_i);
    cfg_r_ready_i <= 1'b1;
    wait_for("r_valid", 1'b0);
  endtask

  task automatic clear_counters();
    @(posedge clk_i);
    cfg_b_ready_i  <= 1'b0;
    cfg_aw_valid_i <= 1'b1;
    cfg_w_valid_i  <= 1'b1;
    wait_for("aw_ready", 1'b1);
    @(posedge clk_i);
    cfg_aw_valid_i <= 1'b0;
    cfg_w_valid_i  <= 1'b0;
    wait_for("b_valid", 1'b1);
    for (int c = 0; c < 4; c++) begin
      @(negedge clk_i);
      checks++;
      assert (cfg_b_valid_o && !cfg_aw_ready_o && !cfg_w_ready_o) else begin
        $display("Fail %0t: write response not held while b_ready is low", $time);
        errors++;
      end
    end
    @(posedge clk_i);
    cfg_b_ready_i <= 1'b1;
    wait_for("b_valid", 1'b0);
    for (int n = 0; n < mon_pkg::NumCounters; n++) begin
      ref_cnt[n] = 0;
    end
  endtask

  task automatic end_test(string name);
    $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial begin
    void'($urandom(32'h14d3_d6ea));
    rst_i           = 1'b1;
    acc_valid_i     = 1'b0;
    acc_addr_i      = '0;
    acc_write_i     = 1'b0;
    acc_hit_i       = 1'b0;
    dma_evt_valid_i = 1'b0;
    cfg_ar_valid_i  = 1'b0;
    cfg_ar_addr_i   = '0;
    cfg_r_ready_i   = 1'b1;
    cfg_aw_valid_i  = 1'b0;
    cfg_w_valid_i   = 1'b0;
    cfg_b_ready_i   = 1'b1;
    checks          = 0;
    errors          = 0;
    test_checks     = 0;
    test_errors     = 0;
    for (int n = 0; n < mon_pkg::NumCounters; n++) begin
      ref_cnt[n] = 0;
    end
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    check_all_counters();
    check_counter(mon_pkg::NumCounters, mon_pkg::UnmappedData);
    check_counter(255, mon_pkg::UnmappedData);
    end_test("reset values");

    random_accesses(200);
    check_all_counters();
    end_test("random accesses");

    for (int r = 0; r < 5; r++) begin
      dma_request();
    end
    check_counter(mon_pkg::DmaCntIdx, ref_cnt[mon_pkg::DmaCntIdx]);
    end_test("dma requests");

    held_read();
    end_test("held read response");

    clear_counters();
    check_all_counters();
    random_accesses(40);
    check_all_counters();
    end_test("clear and recount");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
